// ==== common/wb_defines.svh ====
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// entries in the commit queue
`define WB_QUEUE_DEPTH 4

// general registers, eax through edi
`define WB_GPR_COUNT 8

// alu op that marks an exchange
`define WB_XCHG_OP 14

// register and address widths
`define WB_DATA_W 32
`define WB_ADDR_W 32

`endif

// ==== common/mem_pkg.sv ====
`include "wb_defines.svh"

package mem_pkg;

   // data memory write address
   typedef logic [`WB_ADDR_W-1:0] mem_addr_t;

   // write size as seen by the data memory
   typedef enum logic [1:0] {
      MEM_SIZE_BYTE  = 2'd0,
      MEM_SIZE_WORD  = 2'd1,
      MEM_SIZE_DWORD = 2'd2,
      MEM_SIZE_QWORD = 2'd3
   } mem_size_e;

endpackage

// ==== common/wb_pkg.sv ====
`include "wb_defines.svh"

package wb_pkg;

   import mem_pkg::*;

   // operand size, same coding as the decode side
   typedef enum logic [2:0] {
      OPSIZE_BYTE  = 3'd1,
      OPSIZE_WORD  = 3'd2,
      OPSIZE_DWORD = 3'd3,
      OPSIZE_QWORD = 3'd4
   } opsize_e;

   // lo is the operand a value, hi the operand b value
   typedef struct packed {
      logic [`WB_DATA_W-1:0] hi;
      logic [`WB_DATA_W-1:0] lo;
   } result_pair_t;

   // execute result, a memory datum or two register values
   typedef union packed {
      logic [2*`WB_DATA_W-1:0] whole;
      result_pair_t            pair;
   } result_u;

   typedef struct packed {
      logic      reg_a_en;
      logic [2:0] reg_a_num;
      logic      reg_b_en;
      logic [2:0] reg_b_num;
      logic      mem_en;
      mem_addr_t mem_addr;
      // exchange store, hi word only
      logic      mem_hi;
      opsize_e   size;
   } wb_cmd_t;

endpackage

// ==== common/wb_req_if.sv ====
interface wb_req_if import wb_pkg::*; ();

   logic    valid;
   logic    ready;
   wb_cmd_t cmd;
   result_u result;
   // work still pending downstream
   logic    busy;

   modport source (
      output valid,
      output cmd,
      output result,
      input  ready,
      input  busy
   );

   modport sink (
      input  valid,
      input  cmd,
      input  result,
      output ready,
      output busy
   );

endinterface

// ==== rtl/wb_classify.sv ====
`include "wb_defines.svh"

module wb_classify import wb_pkg::*, mem_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       flush,
   input  logic       ex_valid,
   output logic       ex_ready,
   input  logic [3:0] ex_alu_op,
   input  opsize_e    ex_opsize,
   input  logic [2:0] ex_dest_reg,
   input  logic [2:0] ex_src_reg,
   input  mem_addr_t  ex_dest_address,
   input  mem_addr_t  ex_src_address,
   input  logic       ex_a_is_reg,
   input  logic       ex_a_is_address,
   input  logic       ex_b_is_reg,
   input  logic       ex_b_is_address,
   input  result_u    ex_result,
   wb_req_if.source   req
);

   logic    is_xchg;
   logic    xchg_mem;
   logic    accept;
   wb_cmd_t cmd_d;
   wb_cmd_t cmd_q;
   result_u result_q;
   logic    valid_q;

   assign is_xchg  = (ex_alu_op == 4'(`WB_XCHG_OP));
   assign xchg_mem = is_xchg & ex_b_is_address;

   always_comb begin
      cmd_d.reg_a_en  = ex_a_is_reg;
      cmd_d.reg_a_num = ex_dest_reg;
      cmd_d.reg_b_en  = is_xchg & ex_b_is_reg;
      cmd_d.reg_b_num = ex_src_reg;
      // exchange to memory goes to the source address
      cmd_d.mem_en    = xchg_mem | ex_a_is_address;
      cmd_d.mem_addr  = xchg_mem ? ex_src_address : ex_dest_address;
      cmd_d.mem_hi    = xchg_mem;
      cmd_d.size      = ex_opsize;
   end

   // slot is free when empty or drained this cycle
   assign ex_ready = ~valid_q | req.ready;
   assign accept   = ex_valid & ex_ready;

   always_ff @(posedge clk) begin
      if (rst || flush) begin
         valid_q <= 1'b0;
      end else if (accept) begin
         valid_q <= 1'b1;
      end else if (req.ready) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_q    <= cmd_d;
         result_q <= ex_result;
      end
   end

   assign req.valid  = valid_q;
   assign req.cmd    = cmd_q;
   assign req.result = result_q;

endmodule

// ==== rtl/wb_queue.sv ====
`include "wb_defines.svh"

module wb_queue import wb_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     flush,
   wb_req_if.sink   wr,
   wb_req_if.source rd
);

   localparam int DEPTH = `WB_QUEUE_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   wb_cmd_t          cmd_mem [DEPTH];
   result_u          res_mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   assign wr.ready = (count != CNT_W'(DEPTH));
   assign rd.valid = (count != '0);
   assign push     = wr.valid & wr.ready;
   assign pop      = rd.valid & rd.ready;

   always_ff @(posedge clk) begin
      if (rst || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         cmd_mem[wr_ptr] <= wr.cmd;
         res_mem[wr_ptr] <= wr.result;
      end
   end

   assign rd.cmd    = cmd_mem[rd_ptr];
   assign rd.result = res_mem[rd_ptr];

   // anything queued or still in commit
   assign wr.busy = rd.busy | (count != '0);

endmodule

// ==== writeback/gpr_file.sv ====
`include "wb_defines.svh"

module gpr_file import wb_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  we1,
   input  logic                  we2,
   input  logic [2:0]            num1,
   input  logic [2:0]            num2,
   input  opsize_e               size1,
   input  opsize_e               size2,
   input  logic [`WB_DATA_W-1:0] data1,
   input  logic [`WB_DATA_W-1:0] data2,
   input  logic [2:0]            rd_reg,
   output logic [`WB_DATA_W-1:0] rd_data
);

   logic [`WB_DATA_W-1:0] regs [`WB_GPR_COUNT];

   // partial writes keep the upper bits
   function automatic logic [`WB_DATA_W-1:0] merge(
      input logic [`WB_DATA_W-1:0] old,
      input logic [`WB_DATA_W-1:0] data,
      input opsize_e               size
   );
      case (size)
         OPSIZE_BYTE: return {old[`WB_DATA_W-1:8], data[7:0]};
         OPSIZE_WORD: return {old[`WB_DATA_W-1:16], data[15:0]};
         default:     return data;
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `WB_GPR_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (we1 && we2 && num1 == num2) begin
         // port 2 lands on top of port 1
         regs[num2] <= merge(merge(regs[num1], data1, size1), data2, size2);
      end else begin
         if (we1) begin
            regs[num1] <= merge(regs[num1], data1, size1);
         end
         if (we2) begin
            regs[num2] <= merge(regs[num2], data2, size2);
         end
      end
   end

   assign rd_data = regs[rd_reg];

endmodule

// ==== writeback/wb_commit.sv ====
`include "wb_defines.svh"

module wb_commit import wb_pkg::*, mem_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    flush,
   wb_req_if.sink                  req,
   input  logic                    dec_wb_valid,
   input  logic [2:0]              dec_wb_reg,
   input  opsize_e                 dec_wb_size,
   input  logic [`WB_DATA_W-1:0]   dec_wb_data,
   output logic                    wmem_valid,
   input  logic                    wmem_ready,
   output mem_addr_t               wmem_address,
   output logic [2*`WB_DATA_W-1:0] wmem_wr_data,
   output mem_size_e               wmem_wr_size,
   input  logic [2:0]              rd_reg,
   output logic [`WB_DATA_W-1:0]   rd_data
);

   wb_cmd_t               cmd_q;
   result_u               result_q;
   logic                  hold_q;
   logic                  reg_done_q;
   logic                  reg_fire;
   logic                  done;
   logic                  load;
   logic                  we1;
   logic                  we2;
   logic [2:0]            num1;
   opsize_e               size1;
   logic [`WB_DATA_W-1:0] data1;

   function automatic mem_size_e map_size(input opsize_e size);
      case (size)
         OPSIZE_BYTE:  return MEM_SIZE_BYTE;
         OPSIZE_WORD:  return MEM_SIZE_WORD;
         OPSIZE_QWORD: return MEM_SIZE_QWORD;
         default:      return MEM_SIZE_DWORD;
      endcase
   endfunction

   // register writes go once, in the first cycle decode leaves the port free
   assign reg_fire = hold_q & ~reg_done_q & ~dec_wb_valid;

   // memory write follows the register writes
   assign wmem_valid   = hold_q & cmd_q.mem_en & reg_done_q;
   assign wmem_address = cmd_q.mem_addr;
   assign wmem_wr_data = cmd_q.mem_hi ? {{`WB_DATA_W{1'b0}}, result_q.pair.hi}
                                      : result_q.whole;
   assign wmem_wr_size = map_size(cmd_q.size);

   assign done      = cmd_q.mem_en ? (wmem_valid & wmem_ready) : reg_fire;
   assign req.ready = ~hold_q | done;
   assign req.busy  = hold_q;
   assign load      = req.valid & req.ready;

   always_ff @(posedge clk) begin
      if (rst || flush) begin
         hold_q     <= 1'b0;
         reg_done_q <= 1'b0;
      end else if (load) begin
         hold_q     <= 1'b1;
         reg_done_q <= 1'b0;
      end else if (done) begin
         hold_q <= 1'b0;
      end else if (reg_fire) begin
         reg_done_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         cmd_q    <= req.cmd;
         result_q <= req.result;
      end
   end

   // decode owns port 1 in its strobe cycle
   assign we1   = dec_wb_valid | (reg_fire & cmd_q.reg_a_en);
   assign num1  = dec_wb_valid ? dec_wb_reg : cmd_q.reg_a_num;
   assign size1 = dec_wb_valid ? dec_wb_size : cmd_q.size;
   assign data1 = dec_wb_valid ? dec_wb_data : result_q.pair.lo;
   assign we2   = reg_fire & cmd_q.reg_b_en;

   gpr_file u_gpr (
      .clk    (clk),
      .rst    (rst),
      .we1    (we1),
      .we2    (we2),
      .num1   (num1),
      .num2   (cmd_q.reg_b_num),
      .size1  (size1),
      .size2  (cmd_q.size),
      .data1  (data1),
      .data2  (result_q.pair.hi),
      .rd_reg (rd_reg),
      .rd_data(rd_data)
   );

endmodule

// ==== rtl/writeback_top.sv ====
`include "wb_defines.svh"

module writeback_top import wb_pkg::*, mem_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    flush,
   input  logic                    ex_valid,
   output logic                    ex_ready,
   input  logic [3:0]              ex_alu_op,
   input  opsize_e                 ex_opsize,
   input  logic [2:0]              ex_dest_reg,
   input  logic [2:0]              ex_src_reg,
   input  mem_addr_t               ex_dest_address,
   input  mem_addr_t               ex_src_address,
   input  logic                    ex_a_is_reg,
   input  logic                    ex_a_is_address,
   input  logic                    ex_b_is_reg,
   input  logic                    ex_b_is_address,
   input  result_u                 ex_result,
   input  logic                    dec_wb_valid,
   input  logic [2:0]              dec_wb_reg,
   input  opsize_e                 dec_wb_size,
   input  logic [`WB_DATA_W-1:0]   dec_wb_data,
   output logic                    wmem_valid,
   input  logic                    wmem_ready,
   output mem_addr_t               wmem_address,
   output logic [2*`WB_DATA_W-1:0] wmem_wr_data,
   output mem_size_e               wmem_wr_size,
   input  logic [2:0]              rd_reg,
   output logic [`WB_DATA_W-1:0]   rd_data,
   output logic                    busy
);

   wb_req_if cls_q ();
   wb_req_if q_cmt ();

   wb_classify u_classify (
      .clk            (clk),
      .rst            (rst),
      .flush          (flush),
      .ex_valid       (ex_valid),
      .ex_ready       (ex_ready),
      .ex_alu_op      (ex_alu_op),
      .ex_opsize      (ex_opsize),
      .ex_dest_reg    (ex_dest_reg),
      .ex_src_reg     (ex_src_reg),
      .ex_dest_address(ex_dest_address),
      .ex_src_address (ex_src_address),
      .ex_a_is_reg    (ex_a_is_reg),
      .ex_a_is_address(ex_a_is_address),
      .ex_b_is_reg    (ex_b_is_reg),
      .ex_b_is_address(ex_b_is_address),
      .ex_result      (ex_result),
      .req            (cls_q)
   );

   wb_queue u_queue (
      .clk  (clk),
      .rst  (rst),
      .flush(flush),
      .wr   (cls_q),
      .rd   (q_cmt)
   );

   wb_commit u_commit (
      .clk         (clk),
      .rst         (rst),
      .flush       (flush),
      .req         (q_cmt),
      .dec_wb_valid(dec_wb_valid),
      .dec_wb_reg  (dec_wb_reg),
      .dec_wb_size (dec_wb_size),
      .dec_wb_data (dec_wb_data),
      .wmem_valid  (wmem_valid),
      .wmem_ready  (wmem_ready),
      .wmem_address(wmem_address),
      .wmem_wr_data(wmem_wr_data),
      .wmem_wr_size(wmem_wr_size),
      .rd_reg      (rd_reg),
      .rd_data     (rd_data)
   );

   // classifier slot plus everything behind it
   assign busy = cls_q.busy | cls_q.valid;

endmodule

// ==== testbench/tb_writeback_checks.svh ====
`ifndef TB_WRITEBACK_CHECKS_SVH
`define TB_WRITEBACK_CHECKS_SVH

task automatic check_reg(
   input logic [`WB_DATA_W-1:0] got,
   input logic [`WB_DATA_W-1:0] exp,
   input string                 what
);
   if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      mismatch_count++;
   end
endtask

task automatic check_mem_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
   if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      mismatch_count++;
   end
endtask

task automatic check_mem_size(input mem_size_e got, input mem_size_e exp, input string what);
   if (got !== exp) begin
      $display("FAIL %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
      mismatch_count++;
   end
endtask

// byte and word writes keep the upper bits of the register
function automatic logic [`WB_DATA_W-1:0] sized_update(
   input logic [`WB_DATA_W-1:0] old,
   input logic [`WB_DATA_W-1:0] data,
   input opsize_e               size
);
   if (size == OPSIZE_BYTE) begin
      return {old[`WB_DATA_W-1:8], data[7:0]};
   end
   if (size == OPSIZE_WORD) begin
      return {old[`WB_DATA_W-1:16], data[15:0]};
   end
   return data;
endfunction

function automatic mem_size_e expected_size(input opsize_e size);
   case (size)
      OPSIZE_BYTE:  return MEM_SIZE_BYTE;
      OPSIZE_WORD:  return MEM_SIZE_WORD;
      OPSIZE_DWORD: return MEM_SIZE_DWORD;
      default:      return MEM_SIZE_QWORD;
   endcase
endfunction

`endif

// ==== testbench/tb_writeback.sv ====
`include "wb_defines.svh"

module tb_writeback import wb_pkg::*, mem_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_REG   = 40;
   localparam int N_XCHG  = 30;
   localparam int N_MEM   = 30;
   localparam int N_STALL = 60;
   localparam int N_DEC   = 40;
   localparam int N_TOTAL = N_REG + N_XCHG + N_MEM + N_STALL + N_DEC + 6;

   logic                    clk;
   logic                    rst;
   logic                    flush;
   logic                    ex_valid;
   logic                    ex_ready;
   logic [3:0]              ex_alu_op;
   opsize_e                 ex_opsize;
   logic [2:0]              ex_dest_reg;
   logic [2:0]              ex_src_reg;
   mem_addr_t               ex_dest_address;
   mem_addr_t               ex_src_address;
   logic                    ex_a_is_reg;
   logic                    ex_a_is_address;
   logic                    ex_b_is_reg;
   logic                    ex_b_is_address;
   result_u                 ex_result;
   logic                    dec_wb_valid;
   logic [2:0]              dec_wb_reg;
   opsize_e                 dec_wb_size;
   logic [`WB_DATA_W-1:0]   dec_wb_data;
   logic                    wmem_valid;
   logic                    wmem_ready;
   mem_addr_t               wmem_address;
   logic [2*`WB_DATA_W-1:0] wmem_wr_data;
   mem_size_e               wmem_wr_size;
   logic [2:0]              rd_reg;
   logic [`WB_DATA_W-1:0]   rd_data;
   logic                    busy;

   integer                  seed;
   logic [`WB_DATA_W-1:0]   m_regs [`WB_GPR_COUNT];
   mem_addr_t               exp_addr [$];
   logic [2*`WB_DATA_W-1:0] exp_data [$];
   mem_size_e               exp_size [$];
   bit                      ready_rand;
   bit                      ready_level;
   bit                      dec_on;
   bit                      saw_stall;
   int                      mismatch_count;
   int                      unexpected_count;
   int                      missing_count;
   int                      other_count;

   `include "tb_writeback_checks.svh"

   writeback_top dut (.*);

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // memory ready and decode strobes drawn once per cycle
   always begin
      @(posedge clk);
      #2;
      wmem_ready   = ready_rand ? (($random(seed) & 3) == 0) : ready_level;
      dec_wb_valid = 1'b0;
      if (dec_on && (($random(seed) & 3) == 0)) begin
         dec_wb_valid = 1'b1;
         // decode keeps to the upper four registers
         dec_wb_reg   = 3'd4 + 3'($unsigned($random(seed)) % 4);
         dec_wb_size  = opsize_e'(3'd1 + 3'($unsigned($random(seed)) % 4));
         dec_wb_data  = $random(seed);
         m_regs[dec_wb_reg] = sized_update(m_regs[dec_wb_reg], dec_wb_data, dec_wb_size);
      end
   end

   always @(negedge clk) begin : mem_monitor
      logic [2*`WB_DATA_W-1:0] d;
      if (!rst && wmem_valid && wmem_ready) begin
         if (exp_addr.size() == 0) begin
            $display("memory write to %h at %0t with no write expected", wmem_address, $time);
            unexpected_count++;
         end else begin
            d = exp_data.pop_front();
            check_mem_addr(wmem_address, exp_addr.pop_front(), "memory address");
            check_reg(wmem_wr_data[63:32], d[63:32], "memory data hi");
            check_reg(wmem_wr_data[31:0], d[31:0], "memory data lo");
            check_mem_size(wmem_wr_size, exp_size.pop_front(), "memory size");
         end
      end
   end

   initial begin
      repeat (N_TOTAL * 40 + 1000) @(posedge clk);
      $display("watchdog expired, the run did not reach its end");
      $display("TESTBENCH FAILED");
      $finish;
   end

   task automatic sync();
      @(posedge clk);
      #2;
   endtask

   // model of one accepted result
   task automatic record_accept();
      logic xchg;
      xchg = (ex_alu_op == 4'(`WB_XCHG_OP));
      if (ex_a_is_reg) begin
         m_regs[ex_dest_reg] = sized_update(m_regs[ex_dest_reg], ex_result.pair.lo, ex_opsize);
      end
      if (xchg && ex_b_is_reg) begin
         m_regs[ex_src_reg] = sized_update(m_regs[ex_src_reg], ex_result.pair.hi, ex_opsize);
      end
      if (xchg && ex_b_is_address) begin
         exp_addr.push_back(ex_src_address);
         exp_data.push_back({32'h0, ex_result.pair.hi});
         exp_size.push_back(expected_size(ex_opsize));
      end else if (ex_a_is_address) begin
         exp_addr.push_back(ex_dest_address);
         exp_data.push_back(ex_result.whole);
         exp_size.push_back(expected_size(ex_opsize));
      end
   endtask

   // kind 0 reg, 1 exchange reg, 2 memory, 3 memory only, 4 low regs mixed
   task automatic send_random(input int kind);
      int   k;
      logic xchg;
      k    = (kind == 4) ? int'($unsigned($random(seed)) % 2) : kind;
      xchg = (k == 1) || (k >= 2 && ($random(seed) & 1));
      ex_result.whole = {$random(seed), $random(seed)};
      ex_opsize       = opsize_e'(3'd1 + 3'($unsigned($random(seed)) % 4));
      ex_alu_op       = xchg ? 4'(`WB_XCHG_OP) : 4'($unsigned($random(seed)) % 14);
      ex_dest_reg     = 3'($random(seed));
      ex_src_reg      = ($random(seed) & 1) ? ex_dest_reg : 3'($random(seed));
      if (kind == 4) begin
         ex_dest_reg[2] = 1'b0;
         ex_src_reg[2]  = 1'b0;
      end
      ex_dest_address = $random(seed);
      ex_src_address  = $random(seed);
      ex_a_is_reg     = (k == 3) ? 1'b0 : (k == 2) ? 1'($random(seed)) : 1'b1;
      ex_b_is_reg     = (k == 1) || (k == 0 && 1'($random(seed)));
      ex_a_is_address = (k >= 2) && !xchg;
      ex_b_is_address = (k >= 2) && xchg;
      ex_valid        = 1'b1;
      @(negedge clk);
      while (!ex_ready) begin
         saw_stall = 1'b1;
         @(negedge clk);
      end
      record_accept();
      @(posedge clk);
      #2;
      ex_valid = 1'b0;
   endtask

   task automatic wait_idle();
      @(negedge clk);
      while (busy) begin
         @(negedge clk);
      end
      if (exp_addr.size() != 0) begin
         $display("%0d expected memory writes never appeared", exp_addr.size());
         missing_count += exp_addr.size();
         exp_addr.delete();
         exp_data.delete();
         exp_size.delete();
      end
   endtask

   task automatic check_all_regs();
      for (int i = 0; i < `WB_GPR_COUNT; i++) begin
         sync();
         rd_reg = 3'(i);
         @(negedge clk);
         check_reg(rd_data, m_regs[i], $sformatf("register %0d", i));
      end
   endtask

   task automatic run_phase(input int n, input int kind);
      sync();
      repeat (n) send_random(kind);
      dec_on = 1'b0;
      wait_idle();
      check_all_regs();
   endtask

   // memory writes stall, then flush or reset drops them
   task automatic abort_test(input bit use_reset);
      ready_level = 1'b0;
      sync();
      repeat (3) send_random(3);
      repeat (3) sync();
      if (use_reset) begin
         rst = 1'b1;
         repeat (4) sync();
         rst = 1'b0;
         for (int i = 0; i < `WB_GPR_COUNT; i++) begin
            m_regs[i] = '0;
         end
      end else begin
         flush = 1'b1;
         sync();
         flush = 1'b0;
      end
      exp_addr.delete();
      exp_data.delete();
      exp_size.delete();
      @(negedge clk);
      if (busy || wmem_valid || !ex_ready) begin
         $display("FAIL %0t: after %s busy=%b wmem_valid=%b ex_ready=%b, expected idle",
                  $time, use_reset ? "reset" : "flush", busy, wmem_valid, ex_ready);
         other_count++;
      end
      ready_level = 1'b1;
      repeat (10) @(negedge clk);
      check_all_regs();
   endtask

   initial begin
      seed = 32'hb339_7991;
      rst = 1'b1;
      flush = 1'b0;
      ex_valid = 1'b0;
      ex_alu_op = '0;
      ex_opsize = OPSIZE_DWORD;
      ex_dest_reg = '0;
      ex_src_reg = '0;
      ex_dest_address = '0;
      ex_src_address = '0;
      ex_a_is_reg = 1'b0;
      ex_a_is_address = 1'b0;
      ex_b_is_reg = 1'b0;
      ex_b_is_address = 1'b0;
      ex_result = '0;
      dec_wb_valid = 1'b0;
      dec_wb_reg = '0;
      dec_wb_size = OPSIZE_DWORD;
      dec_wb_data = '0;
      wmem_ready = 1'b1;
      rd_reg = '0;
      ready_rand = 1'b0;
      ready_level = 1'b1;
      dec_on = 1'b0;
      for (int i = 0; i < `WB_GPR_COUNT; i++) begin
         m_regs[i] = '0;
      end
      repeat (4) sync();
      rst = 1'b0;

      run_phase(N_REG, 0);
      run_phase(N_XCHG, 1);
      run_phase(N_MEM, 2);
      ready_rand = 1'b1;
      saw_stall = 1'b0;
      run_phase(N_STALL, 2);
      ready_rand = 1'b0;
      if (!saw_stall) begin
         $display("ex_ready never fell while memory writes were stalled");
         other_count++;
      end
      dec_on = 1'b1;
      run_phase(N_DEC, 4);
      abort_test(1'b0);
      abort_test(1'b1);

      $display("errors: %0d mismatches, %0d unexpected writes, %0d missing writes, %0d other",
               mismatch_count, unexpected_count, missing_count, other_count);
      if (mismatch_count + unexpected_count + missing_count + other_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+common
+incdir+testbench
common/mem_pkg.sv
common/wb_pkg.sv
common/wb_req_if.sv
rtl/wb_classify.sv
rtl/wb_queue.sv
writeback/gpr_file.sv
writeback/wb_commit.sv
rtl/writeback_top.sv
testbench/tb_writeback.sv

// ==== Bender.yml ====
package:
  name: writeback

sources:
  - include_dirs:
      - common
    files:
      - common/mem_pkg.sv
      - common/wb_pkg.sv
      - common/wb_req_if.sv
      - rtl/wb_classify.sv
      - rtl/wb_queue.sv
      - writeback/gpr_file.sv
      - writeback/wb_commit.sv
      - rtl/writeback_top.sv
  - target: test
    include_dirs:
      - common
      - testbench
    files:
      - testbench/tb_writeback.sv
